// ==== bench/rvExecUnitTb.sv ====
`default_nettype none

module rvExecUnitTb;

    localparam int nAlu = 300;
    localparam int nWord = 200;
    localparam int nUpper = 100;
    localparam int nBranch = 200;
    localparam int nIllegal = 80;
    localparam int totalInstr = nAlu + nWord + nUpper + nBranch + nIllegal;
    // each test adds three idle cycles
    localparam int watchdogCycles = 8 + totalInstr + 3 * 6 + 500;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic [63:0] pc;
    logic [63:0] rs1Data;
    logic [63:0] rs2Data;
    wire         resultValid;
    wire         rdWrite;
    wire  [4:0]  rdAddr;
    wire  [63:0] rdData;
    wire         redirect;
    wire  [63:0] targetPc;
    wire         illegal;

    logic        expWr;
    logic [4:0]  expAddr;
    logic [63:0] expData;
    logic        expRedir;
    logic [63:0] expTgt;
    logic        expIll;

    int errCount = 0;
    int errMark = 0;
    int testCount = 0;
    int instrCount = 0;

    rvExecUnit dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .pc          (pc),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .resultValid (resultValid),
        .rdWrite     (rdWrite),
        .rdAddr      (rdAddr),
        .rdData      (rdData),
        .redirect    (redirect),
        .targetPc    (targetPc),
        .illegal     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // RV64I rules for the kept groups
    function automatic void refModel(input logic [31:0] ins, input logic [63:0] pcV,
                                     input logic [63:0] a, input logic [63:0] b,
                                     output logic wr, output logic [63:0] res,
                                     output logic redir, output logic [63:0] tgt,
                                     output logic ill);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        alt;
        logic [63:0] immI;
        logic [63:0] immU;
        logic [63:0] immB;
        logic [63:0] immJ;
        logic [63:0] op2;
        logic [31:0] w;
        opc = ins[6:0];
        f3 = ins[14:12];
        alt = ins[30];
        immI = {{52{ins[31]}}, ins[31:20]};
        immU = {{32{ins[31]}}, ins[31:12], 12'b0};
        immB = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        wr = 1'b1;
        ill = 1'b0;
        redir = 1'b0;
        res = '0;
        tgt = '0;
        w = '0;
        case (opc)
            7'h33, 7'h13: begin
                op2 = (opc == 7'h33) ? b : immI;
                case (f3)
                    3'd0: res = (opc == 7'h33 && alt) ? a - op2 : a + op2;
                    3'd1: res = a << op2[5:0];
                    3'd2: res = {63'b0, $signed(a) < $signed(op2)};
                    3'd3: res = {63'b0, a < op2};
                    3'd4: res = a ^ op2;
                    3'd5: begin
                        if (alt) res = $signed(a) >>> op2[5:0];
                        else res = a >> op2[5:0];
                    end
                    3'd6: res = a | op2;
                    3'd7: res = a & op2;
                endcase
            end
            7'h3b, 7'h1b: begin
                op2 = (opc == 7'h3b) ? b : immI;
                case (f3)
                    3'd0: w = (opc == 7'h3b && alt) ? a[31:0] - op2[31:0]
                                                    : a[31:0] + op2[31:0];
                    3'd1: w = a[31:0] << op2[4:0];
                    3'd5: begin
                        if (alt) w = $signed(a[31:0]) >>> op2[4:0];
                        else w = a[31:0] >> op2[4:0];
                    end
                    default: ill = 1'b1;
                endcase
                res = {{32{w[31]}}, w};
            end
            7'h37: res = immU;
            7'h17: res = pcV + immU;
            7'h6f: begin
                res = pcV + 64'd4;
                redir = 1'b1;
                tgt = pcV + immJ;
            end
            7'h67: begin
                ill = (f3 != 3'd0);
                res = pcV + 64'd4;
                redir = 1'b1;
                tgt = (a + immI) & ~64'd1;
            end
            7'h63: begin
                wr = 1'b0;
                case (f3)
                    3'd0: redir = (a == b);
                    3'd1: redir = (a != b);
                    3'd4: redir = $signed(a) < $signed(b);
                    3'd5: redir = $signed(a) >= $signed(b);
                    3'd6: redir = a < b;
                    3'd7: redir = a >= b;
                    default: ill = 1'b1;
                endcase
                tgt = pcV + immB;
            end
            // loads, stores and everything else
            default: ill = 1'b1;
        endcase
        if (ill) begin
            wr = 1'b0;
            redir = 1'b0;
        end
        if (ins[11:7] == 5'd0) wr = 1'b0;
    endfunction

    // expected outcome follows the DUT register stage
    always @(posedge clk) begin
        if (instrValid) begin
            refModel(instr, pc, rs1Data, rs2Data, expWr, expData, expRedir, expTgt, expIll);
            expAddr = instr[11:7];
        end
    end

    function automatic int totalErrors();
        return errCount + dut_i.asserts_i.failCount;
    endfunction

    task automatic reportError(input string name, input logic [63:0] expV,
                               input logic [63:0] actV);
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expV, actV);
        errCount++;
    endtask

    // outputs are checked mid-cycle
    chkWrite: assert property (@(negedge clk) disable iff (!rstN)
        resultValid |-> rdWrite == expWr)
        else reportError("rdWrite", 64'(expWr), 64'(rdWrite));
    chkAddr: assert property (@(negedge clk) disable iff (!rstN)
        resultValid && expWr |-> rdAddr == expAddr)
        else reportError("rdAddr", 64'(expAddr), 64'(rdAddr));
    chkData: assert property (@(negedge clk) disable iff (!rstN)
        resultValid && expWr |-> rdData == expData)
        else reportError("rdData", expData, rdData);
    chkRedirect: assert property (@(negedge clk) disable iff (!rstN)
        resultValid |-> redirect == expRedir)
        else reportError("redirect", 64'(expRedir), 64'(redirect));
    chkTarget: assert property (@(negedge clk) disable iff (!rstN)
        resultValid && expRedir |-> targetPc == expTgt)
        else reportError("targetPc", expTgt, targetPc);
    chkIllegal: assert property (@(negedge clk) disable iff (!rstN)
        resultValid |-> illegal == expIll)
        else reportError("illegal", 64'(expIll), 64'(illegal));

    function automatic logic [63:0] randWord();
        logic [2:0] k;
        k = 3'($urandom);
        case (k)
            3'd0: return 64'h8000_0000_0000_0000;
            3'd1: return 64'h7fff_ffff_ffff_ffff;
            3'd2: return '1;
            3'd3: return {32'h0, 32'h8000_0000};
            default: return {32'($urandom), 32'($urandom)};
        endcase
    endfunction

    task automatic issue(input logic [31:0] ins, input logic [63:0] a, input logic [63:0] b);
        @(posedge clk);
        #2;
        instrValid = 1'b1;
        instr = ins;
        pc = {32'($urandom), 30'($urandom), 2'b00};
        rs1Data = a;
        rs2Data = b;
        instrCount++;
    endtask

    task automatic finishTest(input string name, input int n);
        @(posedge clk);
        #2;
        instrValid = 1'b0;
        repeat (2) @(posedge clk);
        testCount++;
        $display("test %-8s %4d instructions, %0d errors", name, n, totalErrors() - errMark);
        errMark = totalErrors();
    endtask

    task automatic aluTest(input int n);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        repeat (n) begin
            f3 = 3'($urandom);
            alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'($urandom) : 1'b0;
            imm12 = 12'($urandom);
            if (f3 == 3'd1 || f3 == 3'd5) imm12 = {1'b0, alt, 4'b0, 6'($urandom)};
            if (1'($urandom))
                issue({1'b0, alt, 5'b0, 5'($urandom), 5'($urandom), f3, 5'($urandom), 7'h33},
                      randWord(), randWord());
            else
                issue({imm12, 5'($urandom), f3, 5'($urandom), 7'h13}, randWord(), randWord());
        end
    endtask

    task automatic wordTest(input int n);
        logic [2:0]  f3;
        logic [1:0]  sel;
        logic        alt;
        logic [11:0] imm12;
        repeat (n) begin
            sel = 2'($urandom % 3);
            f3 = (sel == 2'd0) ? 3'd0 : (sel == 2'd1) ? 3'd1 : 3'd5;
            alt = (f3 == 3'd1) ? 1'b0 : 1'($urandom);
            imm12 = (f3 == 3'd0) ? 12'($urandom) : {1'b0, alt, 5'b0, 5'($urandom)};
            if (1'($urandom))
                issue({1'b0, alt, 5'b0, 5'($urandom), 5'($urandom), f3, 5'($urandom), 7'h3b},
                      randWord(), randWord());
            else
                issue({imm12, 5'($urandom), f3, 5'($urandom), 7'h1b}, randWord(), randWord());
        end
    endtask

    task automatic upperJumpTest(input int n);
        logic [6:0] opc;
        repeat (n) begin
            case (2'($urandom))
                2'd0: opc = 7'h37;
                2'd1: opc = 7'h17;
                2'd2: opc = 7'h6f;
                default: opc = 7'h67;
            endcase
            if (opc == 7'h67)
                issue({12'($urandom), 5'($urandom), 3'b000, 5'($urandom), opc},
                      randWord(), randWord());
            else
                issue({20'($urandom), 5'($urandom), opc}, randWord(), randWord());
        end
    endtask

    task automatic branchTest(input int n);
        logic [2:0]  f3;
        logic [63:0] a;
        logic [63:0] b;
        repeat (n) begin
            f3 = 3'($urandom);
            if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
            a = randWord();
            b = randWord();
            case (2'($urandom))
                2'd0: b = a;
                2'd1: begin
                    a = 64'h8000_0000_0000_0000;
                    b = 64'h7fff_ffff_ffff_ffff;
                end
                default: ;
            endcase
            issue({7'($urandom), 5'($urandom), 5'($urandom), f3, 5'($urandom), 7'h63}, a, b);
        end
    endtask

    task automatic illegalTest(input int n);
        logic [2:0] f3;
        repeat (n) begin
            f3 = {1'b1, 2'($urandom)};
            if (f3 == 3'd5) f3 = 3'd2;
            case (3'($urandom))
                3'd0: issue({25'($urandom), 7'h03}, randWord(), randWord());
                3'd1: issue({25'($urandom), 7'h23}, randWord(), randWord());
                3'd2: issue({25'($urandom), 7'h73}, randWord(), randWord());
                3'd3: issue({25'($urandom), 7'h0f}, randWord(), randWord());
                3'd4: issue({17'($urandom), f3, 5'($urandom), 7'h3b}, randWord(), randWord());
                3'd5: issue({17'($urandom), 3'($urandom) | 3'd1, 5'($urandom), 7'h67},
                            randWord(), randWord());
                // legal ones aimed at x0
                3'd6: issue({7'b0, 10'($urandom), 3'b000, 5'd0, 7'h33}, randWord(), randWord());
                default: issue({20'($urandom), 5'd0, 7'h6f}, randWord(), randWord());
            endcase
        end
    endtask

    initial begin : watchdog
        #(watchdogCycles * 20);
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h4955_eea0));
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        pc = '0;
        rs1Data = '0;
        rs2Data = '0;
        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;
        finishTest("reset", 0);
        aluTest(nAlu);
        finishTest("alu", nAlu);
        wordTest(nWord);
        finishTest("word", nWord);
        upperJumpTest(nUpper);
        finishTest("upper", nUpper);
        branchTest(nBranch);
        finishTest("branch", nBranch);
        illegalTest(nIllegal);
        finishTest("illegal", nIllegal);
        $display("%0d tests, %0d instructions, %0d errors", testCount, instrCount,
                 totalErrors());
        if (totalErrors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/rvExecUnit_asserts.sv ====
`default_nettype none

module rvExecUnit_asserts (
    input wire       clk,
    input wire       rstN,
    input wire       instrValid,
    input wire       resultValid,
    input wire       rdWrite,
    input wire [4:0] rdAddr,
    input wire       redirect,
    input wire       illegal
);

    int failCount = 0;

    // outputs stay quiet through reset and the first cycle after it
    resetQuiet: assert property (@(posedge clk)
        !rstN |=> !resultValid && !rdWrite && !redirect && !illegal)
        else begin
            failCount++;
            $error("outputs active during reset");
        end

    validFollows: assert property (@(posedge clk) disable iff (!rstN)
        instrValid |=> resultValid)
        else begin
            failCount++;
            $error("resultValid missing one cycle after instrValid");
        end

    validSingle: assert property (@(posedge clk) disable iff (!rstN)
        !instrValid |=> !resultValid)
        else begin
            failCount++;
            $error("resultValid without an instruction");
        end

    writeGated: assert property (@(posedge clk) disable iff (!rstN)
        (rdWrite || redirect) |-> resultValid)
        else begin
            failCount++;
            $error("rdWrite or redirect high without resultValid");
        end

    noX0Write: assert property (@(posedge clk) disable iff (!rstN)
        rdWrite |-> rdAddr != 5'd0)
        else begin
            failCount++;
            $error("write to x0");
        end

    illegalNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        illegal |-> resultValid && !rdWrite && !redirect)
        else begin
            failCount++;
            $error("illegal instruction still writes or redirects");
        end

endmodule

bind rvExecUnit rvExecUnit_asserts asserts_i (.*);

`default_nettype wire

// ==== include/rvOpcodes.svh ====
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// major opcodes, instr[6:0]
localparam logic [6:0] opcodeOp      = 7'b0110011;
localparam logic [6:0] opcodeOpImm   = 7'b0010011;
localparam logic [6:0] opcodeOp32    = 7'b0111011;
localparam logic [6:0] opcodeOpImm32 = 7'b0011011;
localparam logic [6:0] opcodeLui     = 7'b0110111;
localparam logic [6:0] opcodeAuipc   = 7'b0010111;
localparam logic [6:0] opcodeJal     = 7'b1101111;
localparam logic [6:0] opcodeJalr    = 7'b1100111;
localparam logic [6:0] opcodeBranch  = 7'b1100011;

// memory ops, recognized only so they can be rejected
localparam logic [6:0] opcodeLoad    = 7'b0000011;
localparam logic [6:0] opcodeStore   = 7'b0100011;

// funct3 for OP, OP-IMM and the W forms
// bit 30 splits add/sub and srl/sra
localparam logic [2:0] f3AddSub      = 3'b000;
localparam logic [2:0] f3Sll         = 3'b001;
localparam logic [2:0] f3Slt         = 3'b010;
localparam logic [2:0] f3Sltu        = 3'b011;
localparam logic [2:0] f3Xor         = 3'b100;
localparam logic [2:0] f3SrlSra      = 3'b101;
localparam logic [2:0] f3Or          = 3'b110;
localparam logic [2:0] f3And         = 3'b111;

// funct3 for conditional branches
localparam logic [2:0] f3Beq         = 3'b000;
localparam logic [2:0] f3Bne         = 3'b001;
localparam logic [2:0] f3Blt         = 3'b100;
localparam logic [2:0] f3Bge         = 3'b101;
localparam logic [2:0] f3Bltu        = 3'b110;
localparam logic [2:0] f3Bgeu        = 3'b111;

// jalr has a single legal funct3
localparam logic [2:0] f3Jalr        = 3'b000;

`endif

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f rvExecUnit.f --top-module rvExecUnitTb -o simv ||
    { echo "build failed"; exit 1; }
./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

// ==== rvExecUnit.f ====
+incdir+include
verilog/rvExecPkg.sv
verilog/instrDecoder.sv
verilog/aluExecute.sv
verilog/resultStage.sv
verilog/rvExecUnit.sv
bench/rvExecUnit_asserts.sv
bench/rvExecUnitTb.sv

// ==== verilog/aluExecute.sv ====
`default_nettype none

module aluExecute
    import rvExecPkg::*;
(
    input  wire ctrlT  ctrl,
    input  wire word64 imm,
    input  wire word64 pc,
    input  wire word64 rs1Data,
    input  wire word64 rs2Data,
    output word64      aluResult,
    output logic       condTrue
);

    localparam int ShamtW = $clog2(XLEN);
    localparam int HalfW = XLEN / 2;

    word64             opB;
    word64             rawRes;
    word64             rs1Sext;
    word64             rs1Zext;
    logic [ShamtW-1:0] shamt;
    logic              sLess;
    logic              uLess;

    always_comb begin
        unique case (ctrl.src)
            srcReg:             opB = rs2Data;
            srcImm, srcShamt:   opB = imm;
            srcPcImm:           opB = pc + imm;
            srcPc4:             opB = pc + word64'(4);
            default:            opB = rs2Data;
        endcase
    end

    // W shifts only look at five bits
    assign shamt = ctrl.isWord ? {1'b0, opB[ShamtW-2:0]} : opB[ShamtW-1:0];

    assign rs1Sext = {{HalfW{rs1Data[HalfW-1]}}, rs1Data[HalfW-1:0]};
    assign rs1Zext = {{HalfW{1'b0}}, rs1Data[HalfW-1:0]};

    assign sLess = $signed(rs1Data) < $signed(opB);
    assign uLess = rs1Data < opB;

    always_comb begin
        case (ctrl.aluFn)
            aluAdd, aluAddw: rawRes = rs1Data + opB;
            aluSub, aluSubw: rawRes = rs1Data - opB;
            aluXor:          rawRes = rs1Data ^ opB;
            aluOr:           rawRes = rs1Data | opB;
            aluAnd:          rawRes = rs1Data & opB;
            aluSLess:        rawRes = {{(XLEN-1){1'b0}}, sLess};
            aluULess:        rawRes = {{(XLEN-1){1'b0}}, uLess};
            aluSll, aluSllw: rawRes = rs1Data << shamt;
            aluSrl:          rawRes = rs1Data >> shamt;
            aluSrlw:         rawRes = rs1Zext >> shamt;
            aluSra:          rawRes = $signed(rs1Data) >>> shamt;
            aluSraw:         rawRes = $signed(rs1Sext) >>> shamt;
            aluBranch:       rawRes = rs1Data - opB;
            // lui, auipc and the jump link value come straight from the mux
            aluLink:         rawRes = opB;
            default:         rawRes = '0;
        endcase
    end

    assign aluResult = ctrl.isWord ? {{HalfW{rawRes[HalfW-1]}}, rawRes[HalfW-1:0]}
                                   : rawRes;

    always_comb begin
        case (ctrl.branch)
            brEq:           condTrue = (rs1Data == opB);
            brNe:           condTrue = (rs1Data != opB);
            brLt:           condTrue = sLess;
            brLtu:          condTrue = uLess;
            brGe:           condTrue = !sLess;
            brGeu:          condTrue = !uLess;
            brJal, brJalr:  condTrue = 1'b1;
            default:        condTrue = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`default_nettype none

module instrDecoder
    import rvExecPkg::*;
(
    input  wire word32 instr,
    output ctrlT       ctrl,
    output word64      imm,
    output regIdx      rd,
    output regIdx      rs1Idx
);

    logic [6:0] opcode;
    logic [2:0] f3;
    logic       f7Bit;
    immKind     immFmt;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7Bit  = instr[30];
    assign rd     = instr[11:7];
    assign rs1Idx = instr[19:15];

    always_comb begin
        ctrl = '0;
        ctrl.aluFn = aluUnknown;
        ctrl.src = srcReg;
        ctrl.branch = brNone;
        immFmt = immNone;
        unique case (opcode)
            opcodeOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.src = srcImm;
                immFmt = immI;
                unique case (f3)
                    f3AddSub: ctrl.aluFn = aluAdd;
                    f3Xor:    ctrl.aluFn = aluXor;
                    f3Or:     ctrl.aluFn = aluOr;
                    f3And:    ctrl.aluFn = aluAnd;
                    f3Slt:    ctrl.aluFn = aluSLess;
                    f3Sltu:   ctrl.aluFn = aluULess;
                    f3Sll: begin
                        ctrl.aluFn = aluSll;
                        ctrl.src = srcShamt;
                    end
                    f3SrlSra: begin
                        ctrl.aluFn = f7Bit ? aluSra : aluSrl;
                        ctrl.src = srcShamt;
                    end
                endcase
            end
            opcodeOp: begin
                ctrl.regWrite = 1'b1;
                unique case (f3)
                    f3AddSub: ctrl.aluFn = f7Bit ? aluSub : aluAdd;
                    f3Xor:    ctrl.aluFn = aluXor;
                    f3Or:     ctrl.aluFn = aluOr;
                    f3And:    ctrl.aluFn = aluAnd;
                    f3Slt:    ctrl.aluFn = aluSLess;
                    f3Sltu:   ctrl.aluFn = aluULess;
                    f3Sll:    ctrl.aluFn = aluSll;
                    f3SrlSra: ctrl.aluFn = f7Bit ? aluSra : aluSrl;
                endcase
            end
            opcodeOpImm32: begin
                ctrl.regWrite = 1'b1;
                ctrl.isWord = 1'b1;
                immFmt = immI;
                case (f3)
                    f3AddSub: begin
                        ctrl.aluFn = aluAddw;
                        ctrl.src = srcImm;
                    end
                    f3Sll: begin
                        ctrl.aluFn = aluSllw;
                        ctrl.src = srcShamt;
                    end
                    f3SrlSra: begin
                        ctrl.aluFn = f7Bit ? aluSraw : aluSrlw;
                        ctrl.src = srcShamt;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            opcodeOp32: begin
                ctrl.regWrite = 1'b1;
                ctrl.isWord = 1'b1;
                case (f3)
                    f3AddSub: ctrl.aluFn = f7Bit ? aluSubw : aluAddw;
                    f3Sll:    ctrl.aluFn = aluSllw;
                    f3SrlSra: ctrl.aluFn = f7Bit ? aluSraw : aluSrlw;
                    default:  ctrl.illegal = 1'b1;
                endcase
            end
            opcodeBranch: begin
                ctrl.aluFn = aluBranch;
                immFmt = immB;
                case (f3)
                    f3Beq:   ctrl.branch = brEq;
                    f3Bne:   ctrl.branch = brNe;
                    f3Blt:   ctrl.branch = brLt;
                    f3Bltu:  ctrl.branch = brLtu;
                    f3Bge:   ctrl.branch = brGe;
                    f3Bgeu:  ctrl.branch = brGeu;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            opcodeLui, opcodeAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluFn = aluLink;
                ctrl.src = (opcode == opcodeLui) ? srcImm : srcPcImm;
                immFmt = immU;
            end
            opcodeJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluFn = aluLink;
                ctrl.src = srcPc4;
                ctrl.branch = brJal;
                immFmt = immJ;
            end
            opcodeJalr: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluFn = aluLink;
                ctrl.src = srcPc4;
                ctrl.branch = brJalr;
                ctrl.illegal = (f3 != f3Jalr);
                immFmt = immI;
            end
            // no memory port here, loads and stores trap
            opcodeLoad: begin
                ctrl.illegal = 1'b1;
                immFmt = immI;
            end
            opcodeStore: begin
                ctrl.illegal = 1'b1;
                immFmt = immS;
            end
            default: ctrl.illegal = 1'b1;
        endcase
        if (ctrl.illegal) begin
            ctrl.regWrite = 1'b0;
            ctrl.branch = brNone;
        end
    end

    always_comb begin
        case (immFmt)
            immI:    imm = {{52{instr[31]}}, instr[31:20]};
            immU:    imm = {{32{instr[31]}}, instr[31:12], 12'b0};
            immB:    imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            immS:    imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
            immJ:    imm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/resultStage.sv ====
`default_nettype none

module resultStage
    import rvExecPkg::*;
(
    input  wire        clk,
    input  wire        rstN,
    input  wire        instrValid,
    input  wire ctrlT  ctrl,
    input  wire word64 imm,
    input  wire word64 pc,
    input  wire word64 rs1Data,
    input  wire word64 aluResult,
    input  wire        condTrue,
    input  wire regIdx rd,
    output logic       resultValid,
    output logic       rdWrite,
    output regIdx      rdAddr,
    output word64      rdData,
    output logic       redirect,
    output word64      targetPc,
    output logic       illegal
);

    word64 jalrSum;
    word64 targetNext;
    logic  writeEn;
    logic  takeRedirect;

    // jalr target drops bit 0
    assign jalrSum = rs1Data + imm;
    assign targetNext = (ctrl.branch == brJalr) ? {jalrSum[XLEN-1:1], 1'b0} : pc + imm;

    assign takeRedirect = (ctrl.branch != brNone) && condTrue;
    assign writeEn = ctrl.regWrite && !ctrl.illegal && (rd != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            rdWrite <= 1'b0;
            redirect <= 1'b0;
            illegal <= 1'b0;
        end else begin
            resultValid <= instrValid;
            rdWrite <= instrValid && writeEn;
            redirect <= instrValid && takeRedirect;
            illegal <= instrValid && ctrl.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            rdAddr <= rd;
            rdData <= aluResult;
            targetPc <= targetNext;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rvExecPkg.sv ====
`default_nettype none

package rvExecPkg;

    `include "rvOpcodes.svh"

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] word64;
    typedef logic [31:0]     word32;
    typedef logic [4:0]      regIdx;

    typedef enum logic [4:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluOr,
        aluAnd,
        aluSLess,
        aluULess,
        aluSll,
        aluSrl,
        aluSra,
        aluAddw,
        aluSubw,
        aluSllw,
        aluSrlw,
        aluSraw,
        aluBranch,
        aluLink,
        aluUnknown
    } aluOp;

    // second operand, and the result for link ops
    typedef enum logic [2:0] {
        srcReg,
        srcImm,
        srcShamt,
        srcPcImm,
        srcPc4
    } opSrc;

    typedef enum logic [2:0] {
        immNone,
        immI,
        immU,
        immB,
        immS,
        immJ
    } immKind;

    typedef enum logic [3:0] {
        brNone,
        brEq,
        brNe,
        brLt,
        brLtu,
        brGe,
        brGeu,
        brJal,
        brJalr
    } branchKind;

    typedef struct packed {
        logic      regWrite;
        aluOp      aluFn;
        opSrc      src;
        branchKind branch;
        logic      isWord;
        logic      illegal;
    } ctrlT;

endpackage

`default_nettype wire

// ==== verilog/rvExecUnit.sv ====
`default_nettype none

module rvExecUnit
    import rvExecPkg::*;
(
    input  wire        clk,
    input  wire        rstN,
    input  wire        instrValid,
    input  wire word32 instr,
    input  wire word64 pc,
    input  wire word64 rs1Data,
    input  wire word64 rs2Data,
    output logic       resultValid,
    output logic       rdWrite,
    output regIdx      rdAddr,
    output word64      rdData,
    output logic       redirect,
    output word64      targetPc,
    output logic       illegal
);

    ctrlT  ctrl;
    word64 imm;
    word64 aluResult;
    regIdx rd;
    logic  condTrue;

    // rs1 index feeds the register file, which lives outside this slice
    instrDecoder decoder_i (
        .instr  (instr),
        .ctrl   (ctrl),
        .imm    (imm),
        .rd     (rd),
        .rs1Idx ()
    );

    aluExecute alu_i (
        .ctrl      (ctrl),
        .imm       (imm),
        .pc        (pc),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .aluResult (aluResult),
        .condTrue  (condTrue)
    );

    resultStage result_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .ctrl        (ctrl),
        .imm         (imm),
        .pc          (pc),
        .rs1Data     (rs1Data),
        .aluResult   (aluResult),
        .condTrue    (condTrue),
        .rd          (rd),
        .resultValid (resultValid),
        .rdWrite     (rdWrite),
        .rdAddr      (rdAddr),
        .rdData      (rdData),
        .redirect    (redirect),
        .targetPc    (targetPc),
        .illegal     (illegal)
    );

endmodule

`default_nettype wire
